//--- hdl/decode_cfg.svh
// bundle width and tag widths; DEC_WIDTH of 2 or 4 is supported, tag widths must be at least 1
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// instruction slots per fetch bundle
`define DEC_WIDTH 2

// fetch-target-queue id width
`define FTQ_ID_W 4

// fetch epoch width, passed through untouched
`define FETCH_EPOCH_W 2

`endif

//--- hdl/core_types_pkg.sv
// fetch-side types sized from decode_cfg.svh; slot layout is packed, slot_valid in the msb
`default_nettype none

`include "decode_cfg.svh"

package core_types_pkg;

  typedef logic [31:0] inst_t;
  typedef logic [31:0] addr_t;

  typedef logic [`FTQ_ID_W-1:0]      ftq_id_t;
  typedef logic [`FETCH_EPOCH_W-1:0] epoch_t;

  // one fetched instruction plus its prediction and tags
  typedef struct packed {
    logic    slot_valid;
    inst_t   inst;
    addr_t   pc;
    addr_t   pred_npc;  // next pc predicted by fetch
    ftq_id_t ftq_id;
    epoch_t  epoch;
  } fetch_slot_t;

  // slot 0 is the oldest instruction
  typedef fetch_slot_t [`DEC_WIDTH-1:0] fetch_bundle_t;

endpackage

`default_nettype wire

//--- hdl/decode_pkg.sv
// decode-side types for RV32I only; every op enum encodes none as zero so a cleared uop means no op
`default_nettype none

`include "decode_cfg.svh"

package decode_pkg;

  // base opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OPC_LUI      = 7'b0110111,
    OPC_AUIPC    = 7'b0010111,
    OPC_JAL      = 7'b1101111,
    OPC_JALR     = 7'b1100111,
    OPC_BRANCH   = 7'b1100011,
    OPC_LOAD     = 7'b0000011,
    OPC_STORE    = 7'b0100011,
    OPC_OP_IMM   = 7'b0010011,
    OPC_OP       = 7'b0110011,
    OPC_MISC_MEM = 7'b0001111,  // fence, decoded as illegal
    OPC_SYSTEM   = 7'b1110011   // ecall/csr, decoded as illegal
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI
  } alu_op_e;

  // nine values, so 4 bits
  typedef enum logic [3:0] {
    LSU_NONE, LSU_LB, LSU_LH, LSU_LW, LSU_LBU, LSU_LHU, LSU_SB, LSU_SH, LSU_SW
  } lsu_op_e;

  typedef enum logic [3:0] {
    BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
  } br_op_e;

  typedef enum logic [1:0] {
    FU_NONE, FU_ALU, FU_LSU, FU_BRU
  } fu_e;

  typedef struct packed {
    logic                   valid;
    logic                   illegal;
    logic [4:0]             rs1;
    logic [4:0]             rs2;
    logic [4:0]             rd;
    logic [31:0]            imm;  // already sign-extended
    alu_op_e                alu_op;
    lsu_op_e                lsu_op;
    br_op_e                 br_op;
    fu_e                    fu;
    logic                   is_load;
    logic                   is_store;
    logic                   is_jump;
    core_types_pkg::addr_t  pc;
    core_types_pkg::addr_t  pred_npc;
    core_types_pkg::ftq_id_t ftq_id;
    core_types_pkg::epoch_t epoch;
  } uop_t;

  typedef uop_t [`DEC_WIDTH-1:0] uop_bundle_t;

endpackage

`default_nettype wire

//--- hdl/pipe_reg.sv
// one-entry valid/ready register; in_ready_o depends combinationally on out_ready_i
`default_nettype none

module pipe_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic in_valid_i,
  output logic in_ready_o,
  input  T     in_data_i,
  output logic out_valid_o,
  input  logic out_ready_i,
  output T     out_data_o
);

  logic valid_q;
  T     data_q;

  // empty, or the current entry leaves this cycle
  assign in_ready_o = ~valid_q | out_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_data_i;  // captured on a transfer
    end
  end

  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

endmodule

`default_nettype wire

//--- hdl/inst_decoder.sv
// RV32I only; fence, system, compressed and M/A/F encodings come out as illegal with no op
`default_nettype none

module inst_decoder (
  input  core_types_pkg::fetch_slot_t slot_i,
  output decode_pkg::uop_t            uop_o
);

  import core_types_pkg::*;
  import decode_pkg::*;

  inst_t       inst;
  opcode_e     opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  logic [31:0] imm_sh;
  uop_t        dec;      // raw decode, before masking
  logic        illegal;

  // shared by OP and OP-IMM, funct7 checked by the caller
  function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign inst   = slot_i.inst;
  assign opcode = opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign imm_i  = {{20{inst[31]}}, inst[31:20]};
  assign imm_s  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b  = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u  = {inst[31:12], 12'b0};
  assign imm_j  = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_sh = {27'b0, inst[24:20]};  // shamt only, funct7 not folded in

  always_comb begin
    dec     = '0;
    illegal = 1'b0;
    case (opcode)
      OPC_LUI: begin
        dec.fu     = FU_ALU;
        dec.alu_op = ALU_LUI;
        dec.rd     = inst[11:7];
        dec.imm    = imm_u;
      end
      OPC_AUIPC: begin
        dec.fu     = FU_ALU;
        dec.alu_op = ALU_ADD;  // pc + imm
        dec.rd     = inst[11:7];
        dec.imm    = imm_u;
      end
      OPC_JAL: begin
        dec.fu      = FU_BRU;
        dec.br_op   = BR_JAL;
        dec.is_jump = 1'b1;
        dec.rd      = inst[11:7];
        dec.imm     = imm_j;
      end
      OPC_JALR: begin
        dec.fu      = FU_BRU;
        dec.br_op   = BR_JALR;
        dec.is_jump = 1'b1;
        dec.rs1     = inst[19:15];
        dec.rd      = inst[11:7];
        dec.imm     = imm_i;
        illegal     = (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        dec.fu  = FU_BRU;
        dec.rs1 = inst[19:15];
        dec.rs2 = inst[24:20];
        dec.imm = imm_b;
        case (funct3)
          3'b000:  dec.br_op = BR_BEQ;
          3'b001:  dec.br_op = BR_BNE;
          3'b100:  dec.br_op = BR_BLT;
          3'b101:  dec.br_op = BR_BGE;
          3'b110:  dec.br_op = BR_BLTU;
          3'b111:  dec.br_op = BR_BGEU;
          default: illegal   = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        dec.fu      = FU_LSU;
        dec.is_load = 1'b1;
        dec.rs1     = inst[19:15];
        dec.rd      = inst[11:7];
        dec.imm     = imm_i;
        case (funct3)
          3'b000:  dec.lsu_op = LSU_LB;
          3'b001:  dec.lsu_op = LSU_LH;
          3'b010:  dec.lsu_op = LSU_LW;
          3'b100:  dec.lsu_op = LSU_LBU;
          3'b101:  dec.lsu_op = LSU_LHU;
          default: illegal    = 1'b1;
        endcase
      end
      OPC_STORE: begin
        dec.fu       = FU_LSU;
        dec.is_store = 1'b1;
        dec.rs1      = inst[19:15];
        dec.rs2      = inst[24:20];
        dec.imm      = imm_s;
        case (funct3)
          3'b000:  dec.lsu_op = LSU_SB;
          3'b001:  dec.lsu_op = LSU_SH;
          3'b010:  dec.lsu_op = LSU_SW;
          default: illegal    = 1'b1;
        endcase
      end
      OPC_OP_IMM: begin
        dec.fu  = FU_ALU;
        dec.rs1 = inst[19:15];
        dec.rd  = inst[11:7];
        if (funct3 == 3'b001 || funct3 == 3'b101) begin
          dec.imm    = imm_sh;
          dec.alu_op = alu_from_f3(funct3, funct7[5]);
          illegal    = (funct7 != 7'b0000000) &&
                       !(funct3 == 3'b101 && funct7 == 7'b0100000);
        end else begin
          dec.imm    = imm_i;
          dec.alu_op = alu_from_f3(funct3, 1'b0);  // no subi
        end
      end
      OPC_OP: begin
        dec.fu     = FU_ALU;
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];
        dec.rd     = inst[11:7];
        dec.alu_op = alu_from_f3(funct3, funct7[5]);
        illegal    = (funct7 != 7'b0000000) &&
                     !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      default: illegal = 1'b1;  // fence, system and unknown opcodes
    endcase
  end

  // illegal keeps only valid, the flag and the pass-through fields
  always_comb begin
    uop_o = '0;
    if (slot_i.slot_valid) begin
      if (!illegal) begin
        uop_o = dec;
      end
      uop_o.valid    = 1'b1;
      uop_o.illegal  = illegal;
      uop_o.pc       = slot_i.pc;
      uop_o.pred_npc = slot_i.pred_npc;
      uop_o.ftq_id   = slot_i.ftq_id;
      uop_o.epoch    = slot_i.epoch;
    end
  end

endmodule

`default_nettype wire

//--- hdl/decode_stage.sv
// decodes all slots in parallel; the whole bundle is accepted and released as one unit
`default_nettype none

`include "decode_cfg.svh"

module decode_stage (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          in_valid_i,
  output logic                          in_ready_o,
  input  core_types_pkg::fetch_bundle_t bundle_i,
  output logic                          out_valid_o,
  input  logic                          out_ready_i,
  output decode_pkg::uop_bundle_t       uops_o
);

  import decode_pkg::*;

  uop_bundle_t dec_uops;  // combinational, ahead of the output register

  for (genvar i = 0; i < `DEC_WIDTH; i++) begin : gen_dec
    inst_decoder u_dec (
      .slot_i(bundle_i[i]),
      .uop_o (dec_uops[i])
    );
  end

  // one cycle from ibuf output to here
  pipe_reg #(
    .T(uop_bundle_t)
  ) u_out_reg (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .in_data_i  (dec_uops),
    .out_valid_o(out_valid_o),
    .out_ready_i(out_ready_i),
    .out_data_o (uops_o)
  );

endmodule

`default_nettype wire

//--- hdl/decode_top.sv
// two-cycle decode front end; per-slot ports are packed arrays with slot 0 the oldest
`default_nettype none

`include "decode_cfg.svh"

module decode_top (
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  // fetch side
  input  logic                                          fetch_valid_i,
  output logic                                          fetch_ready_o,
  input  logic [`DEC_WIDTH-1:0]                         fetch_slot_valid_i,
  input  core_types_pkg::inst_t   [`DEC_WIDTH-1:0]      fetch_inst_i,
  input  core_types_pkg::addr_t   [`DEC_WIDTH-1:0]      fetch_pc_i,
  input  core_types_pkg::addr_t   [`DEC_WIDTH-1:0]      fetch_pred_npc_i,
  input  core_types_pkg::ftq_id_t [`DEC_WIDTH-1:0]      fetch_ftq_id_i,
  input  core_types_pkg::epoch_t  [`DEC_WIDTH-1:0]      fetch_epoch_i,
  // backend side
  output logic                                          uop_valid_o,
  input  logic                                          uop_ready_i,
  output logic [`DEC_WIDTH-1:0]                         uop_slot_valid_o,
  output logic [`DEC_WIDTH-1:0]                         uop_illegal_o,
  output logic [`DEC_WIDTH-1:0][4:0]                    uop_rs1_o,
  output logic [`DEC_WIDTH-1:0][4:0]                    uop_rs2_o,
  output logic [`DEC_WIDTH-1:0][4:0]                    uop_rd_o,
  output logic [`DEC_WIDTH-1:0][31:0]                   uop_imm_o,
  output decode_pkg::alu_op_e     [`DEC_WIDTH-1:0]      uop_alu_op_o,
  output decode_pkg::lsu_op_e     [`DEC_WIDTH-1:0]      uop_lsu_op_o,
  output decode_pkg::br_op_e      [`DEC_WIDTH-1:0]      uop_br_op_o,
  output decode_pkg::fu_e         [`DEC_WIDTH-1:0]      uop_fu_o,
  output logic [`DEC_WIDTH-1:0]                         uop_is_load_o,
  output logic [`DEC_WIDTH-1:0]                         uop_is_store_o,
  output logic [`DEC_WIDTH-1:0]                         uop_is_jump_o,
  output core_types_pkg::addr_t   [`DEC_WIDTH-1:0]      uop_pc_o,
  output core_types_pkg::addr_t   [`DEC_WIDTH-1:0]      uop_pred_npc_o,
  output core_types_pkg::ftq_id_t [`DEC_WIDTH-1:0]      uop_ftq_id_o,
  output core_types_pkg::epoch_t  [`DEC_WIDTH-1:0]      uop_epoch_o
);

  import core_types_pkg::*;
  import decode_pkg::*;

  fetch_bundle_t fetch_bundle;
  fetch_bundle_t ibuf_bundle;
  logic          ibuf_valid;  // ibuf register occupied
  logic          ibuf_ready;
  uop_bundle_t   uops;

  for (genvar i = 0; i < `DEC_WIDTH; i++) begin : gen_slot
    // pack fetch ports
    assign fetch_bundle[i].slot_valid = fetch_slot_valid_i[i];
    assign fetch_bundle[i].inst       = fetch_inst_i[i];
    assign fetch_bundle[i].pc         = fetch_pc_i[i];
    assign fetch_bundle[i].pred_npc   = fetch_pred_npc_i[i];
    assign fetch_bundle[i].ftq_id     = fetch_ftq_id_i[i];
    assign fetch_bundle[i].epoch      = fetch_epoch_i[i];

    // unpack micro-ops
    assign uop_slot_valid_o[i] = uops[i].valid;
    assign uop_illegal_o[i]    = uops[i].illegal;
    assign uop_rs1_o[i]        = uops[i].rs1;
    assign uop_rs2_o[i]        = uops[i].rs2;
    assign uop_rd_o[i]         = uops[i].rd;
    assign uop_imm_o[i]        = uops[i].imm;
    assign uop_alu_op_o[i]     = uops[i].alu_op;
    assign uop_lsu_op_o[i]     = uops[i].lsu_op;
    assign uop_br_op_o[i]      = uops[i].br_op;
    assign uop_fu_o[i]         = uops[i].fu;
    assign uop_is_load_o[i]    = uops[i].is_load;
    assign uop_is_store_o[i]   = uops[i].is_store;
    assign uop_is_jump_o[i]    = uops[i].is_jump;
    assign uop_pc_o[i]         = uops[i].pc;
    assign uop_pred_npc_o[i]   = uops[i].pred_npc;
    assign uop_ftq_id_o[i]     = uops[i].ftq_id;
    assign uop_epoch_o[i]      = uops[i].epoch;
  end

  pipe_reg #(
    .T(fetch_bundle_t)
  ) u_ibuf (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .in_valid_i (fetch_valid_i),
    .in_ready_o (fetch_ready_o),
    .in_data_i  (fetch_bundle),
    .out_valid_o(ibuf_valid),
    .out_ready_i(ibuf_ready),
    .out_data_o (ibuf_bundle)
  );

  decode_stage u_dec_stage (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .in_valid_i (ibuf_valid),
    .in_ready_o (ibuf_ready),
    .bundle_i   (ibuf_bundle),
    .out_valid_o(uop_valid_o),
    .out_ready_i(uop_ready_i),
    .uops_o     (uops)
  );

endmodule

`default_nettype wire

//--- test/decode_props.sv
// bound into decode_top; reads the internal uops net and counts bundles held between the ports
`default_nettype none

module decode_props (
  input logic                    clk_i,
  input logic                    rst_i,
  input logic                    fetch_valid_i,
  input logic                    fetch_ready_i,
  input logic                    uop_valid_i,
  input logic                    uop_ready_i,
  input decode_pkg::uop_bundle_t uops_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int in_flight;  // bundles held in ibuf and output register

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      in_flight <= 0;
    end else begin
      in_flight <= in_flight + int'(fetch_valid_i && fetch_ready_i)
                             - int'(uop_valid_i && uop_ready_i);
    end
  end

  // output register empty once reset is seen
  a_reset_clears_valid: assert property (@(posedge clk_i) rst_i |=> !uop_valid_i)
    else $error("uop_valid_o still high after a reset cycle");

  a_hold_under_stall: assert property (@(posedge clk_i) disable iff (rst_i)
    uop_valid_i && !uop_ready_i |=> uop_valid_i && $stable(uops_i))
    else $error("stalled micro-op bundle dropped or changed");

  // an empty ibuf leaves at most one bundle inside
  a_ready_with_room: assert property (@(posedge clk_i) disable iff (rst_i)
    (in_flight < 2) |-> fetch_ready_i)
    else $error("fetch_ready_o low while the ibuf register has room");

endmodule

bind decode_top decode_props u_props (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .fetch_valid_i(fetch_valid_i),
  .fetch_ready_i(fetch_ready_o),
  .uop_valid_i  (uop_valid_o),
  .uop_ready_i  (uop_ready_i),
  .uops_i       (uops)
);

`default_nettype wire

//--- test/tb_decode.sv
// run from the project root; golden record count must be a multiple of DEC_WIDTH
`default_nettype none

`include "decode_cfg.svh"

module tb_decode;
  timeunit 1ns;
  timeprecision 1ps;

  import core_types_pkg::*;
  import decode_pkg::*;

  localparam int NUM_REC     = 24;
  localparam int REC_WORDS   = 19;  // 6 stimulus words, 13 expected words
  localparam int NUM_BUNDLES = NUM_REC / `DEC_WIDTH;
  localparam int WAIT_LIMIT  = 200;

  logic                                 clk_i;
  logic                                 rst_i;
  logic                                 fetch_valid_i;
  logic                                 fetch_ready_o;
  logic [`DEC_WIDTH-1:0]                fetch_slot_valid_i;
  inst_t   [`DEC_WIDTH-1:0]             fetch_inst_i;
  addr_t   [`DEC_WIDTH-1:0]             fetch_pc_i;
  addr_t   [`DEC_WIDTH-1:0]             fetch_pred_npc_i;
  ftq_id_t [`DEC_WIDTH-1:0]             fetch_ftq_id_i;
  epoch_t  [`DEC_WIDTH-1:0]             fetch_epoch_i;
  logic                                 uop_valid_o;
  logic                                 uop_ready_i;
  logic [`DEC_WIDTH-1:0]                uop_slot_valid_o;
  logic [`DEC_WIDTH-1:0]                uop_illegal_o;
  logic [`DEC_WIDTH-1:0][4:0]           uop_rs1_o;
  logic [`DEC_WIDTH-1:0][4:0]           uop_rs2_o;
  logic [`DEC_WIDTH-1:0][4:0]           uop_rd_o;
  logic [`DEC_WIDTH-1:0][31:0]          uop_imm_o;
  alu_op_e [`DEC_WIDTH-1:0]             uop_alu_op_o;
  lsu_op_e [`DEC_WIDTH-1:0]             uop_lsu_op_o;
  br_op_e  [`DEC_WIDTH-1:0]             uop_br_op_o;
  fu_e     [`DEC_WIDTH-1:0]             uop_fu_o;
  logic [`DEC_WIDTH-1:0]                uop_is_load_o;
  logic [`DEC_WIDTH-1:0]                uop_is_store_o;
  logic [`DEC_WIDTH-1:0]                uop_is_jump_o;
  addr_t   [`DEC_WIDTH-1:0]             uop_pc_o;
  addr_t   [`DEC_WIDTH-1:0]             uop_pred_npc_o;
  ftq_id_t [`DEC_WIDTH-1:0]             uop_ftq_id_o;
  epoch_t  [`DEC_WIDTH-1:0]             uop_epoch_o;

  logic [31:0] gold_mem [0:NUM_REC*REC_WORDS-1];
  integer      seed     = 32'hdea;
  int          rx_count = 0;  // bundles taken by the monitor

  decode_top dut0 (.*);

  always #20 clk_i = ~clk_i;

  // random back-pressure with ready about three cycles in four
  always @(negedge clk_i) begin
    uop_ready_i = ($random(seed) & 3) != 0;
  end

  task automatic stop_on_failure();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    stop_on_failure();
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("error %s expected %h actual %h", name, expected, actual);
      stop_on_failure();
    end
  endtask

  // starts on a falling edge and returns on the one after the transfer
  task automatic drive_bundle(input int b);
    int base;
    int waited;
    for (int s = 0; s < `DEC_WIDTH; s++) begin
      base = (b * `DEC_WIDTH + s) * REC_WORDS;
      fetch_slot_valid_i[s] = gold_mem[base][0];
      fetch_inst_i[s]       = gold_mem[base+1];
      fetch_pc_i[s]         = gold_mem[base+2];
      fetch_pred_npc_i[s]   = gold_mem[base+3];
      fetch_ftq_id_i[s]     = gold_mem[base+4][`FTQ_ID_W-1:0];
      fetch_epoch_i[s]      = gold_mem[base+5][`FETCH_EPOCH_W-1:0];
    end
    fetch_valid_i = 1'b1;
    waited = 0;
    @(posedge clk_i);
    while (!fetch_ready_o) begin
      waited++;
      if (waited > WAIT_LIMIT) report_timeout("fetch_ready_o to accept a bundle");
      @(posedge clk_i);
    end
    @(negedge clk_i);
  endtask

  task automatic check_bundle(input int b);
    int    base;
    logic  sv;
    string tag;
    for (int s = 0; s < `DEC_WIDTH; s++) begin
      base = (b * `DEC_WIDTH + s) * REC_WORDS;
      sv   = gold_mem[base][0];
      tag  = $sformatf("bundle %0d slot %0d", b, s);
      check_value({tag, " valid"}, gold_mem[base+6], uop_slot_valid_o[s]);
      check_value({tag, " illegal"}, gold_mem[base+7], uop_illegal_o[s]);
      check_value({tag, " rs1"}, gold_mem[base+8], uop_rs1_o[s]);
      check_value({tag, " rs2"}, gold_mem[base+9], uop_rs2_o[s]);
      check_value({tag, " rd"}, gold_mem[base+10], uop_rd_o[s]);
      check_value({tag, " imm"}, gold_mem[base+11], uop_imm_o[s]);
      check_value({tag, " alu_op"}, gold_mem[base+12], uop_alu_op_o[s]);
      check_value({tag, " lsu_op"}, gold_mem[base+13], uop_lsu_op_o[s]);
      check_value({tag, " br_op"}, gold_mem[base+14], uop_br_op_o[s]);
      check_value({tag, " fu"}, gold_mem[base+15], uop_fu_o[s]);
      check_value({tag, " is_load"}, gold_mem[base+16], uop_is_load_o[s]);
      check_value({tag, " is_store"}, gold_mem[base+17], uop_is_store_o[s]);
      check_value({tag, " is_jump"}, gold_mem[base+18], uop_is_jump_o[s]);
      // tags pass through only for a valid slot
      check_value({tag, " pc"}, sv ? gold_mem[base+2] : 32'h0, uop_pc_o[s]);
      check_value({tag, " pred_npc"}, sv ? gold_mem[base+3] : 32'h0, uop_pred_npc_o[s]);
      check_value({tag, " ftq_id"}, sv ? gold_mem[base+4] : 32'h0, uop_ftq_id_o[s]);
      check_value({tag, " epoch"}, sv ? gold_mem[base+5] : 32'h0, uop_epoch_o[s]);
    end
  endtask

  // in-order monitor
  always @(posedge clk_i) begin
    if (!rst_i && uop_valid_o && uop_ready_i) begin
      if (rx_count >= NUM_BUNDLES) begin
        $display("an extra micro-op bundle came out after the last expected one");
        stop_on_failure();
      end
      check_bundle(rx_count);
      rx_count++;
    end
  end

  initial begin
    int waited;
    clk_i              = 1'b0;
    rst_i              = 1'b1;
    fetch_valid_i      = 1'b0;
    fetch_slot_valid_i = '0;
    fetch_inst_i       = '0;
    fetch_pc_i         = '0;
    fetch_pred_npc_i   = '0;
    fetch_ftq_id_i     = '0;
    fetch_epoch_i      = '0;
    uop_ready_i        = 1'b0;
    $readmemh("test/decode_golden.txt", gold_mem);
    if ($isunknown(gold_mem[NUM_REC*REC_WORDS-1])) begin
      $display("golden file test/decode_golden.txt is missing or too short");
      stop_on_failure();
    end
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    for (int b = 0; b < NUM_BUNDLES; b++) begin
      drive_bundle(b);
    end
    fetch_valid_i = 1'b0;
    waited = 0;
    while (rx_count < NUM_BUNDLES) begin
      waited++;
      if (waited > WAIT_LIMIT) report_timeout("all micro-op bundles at the output");
      @(negedge clk_i);
    end
    repeat (10) @(negedge clk_i);  // catch duplicates
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/decode_golden.txt
// columns: slot_valid inst pc pred_npc ftq_id epoch, then the expected micro-op fields
// valid illegal rs1 rs2 rd imm alu_op lsu_op br_op fu is_load is_store is_jump
1 002081b3 80000000 80000004 0 0 1 0 01 02 03 00000000 1 0 0 1 0 0 0
1 407302b3 80000004 80000008 0 0 1 0 06 07 05 00000000 2 0 0 1 0 0 0
1 40c5d533 80000008 8000000c 1 1 1 0 0b 0c 0a 00000000 8 0 0 1 0 0 0
1 003130b3 8000000c 80000010 1 1 1 0 02 03 01 00000000 5 0 0 1 0 0 0
1 fff20213 80000010 80000014 2 1 1 0 04 00 04 ffffffff 1 0 0 1 0 0 0
1 4034d413 80000014 80000018 2 1 1 0 09 00 08 00000003 8 0 0 1 0 0 0
1 7f00f393 80000018 8000001c 3 2 1 0 01 00 07 000007f0 a 0 0 1 0 0 0
1 ffc12283 8000001c 80000020 3 2 1 0 02 00 05 fffffffc 0 3 0 2 1 0 0
1 0101c303 80000020 80000024 4 2 1 0 03 00 06 00000010 0 4 0 2 1 0 0
1 00712423 80000024 80000028 4 2 1 0 02 07 00 00000008 0 8 0 2 0 1 0
1 fe129f23 80000028 8000002c 5 3 1 0 05 01 00 fffffffe 0 7 0 2 0 1 0
1 00208863 8000002c 8000003c 5 3 1 0 01 02 00 00000010 0 0 1 3 0 0 0
1 fe019ce3 8000003c 80000040 6 3 1 0 03 00 00 fffffff8 0 0 2 3 0 0 0
1 02526063 80000040 80000044 6 3 1 0 04 05 00 00000020 0 0 5 3 0 0 0
1 801ff0ef 80000044 7ffff844 7 0 1 0 00 00 01 fffff800 0 0 7 3 0 0 1
1 00008067 7ffff844 80000048 7 0 1 0 01 00 00 00000000 0 0 8 3 0 0 1
1 12345137 80000048 8000004c 8 1 1 0 00 00 02 12345000 b 0 0 1 0 0 0
1 fffff197 8000004c 80000050 8 1 1 0 00 00 03 fffff000 1 0 0 1 0 0 0
1 0ff0000f 80000050 80000054 9 1 1 1 00 00 00 00000000 0 0 0 0 0 0 0
0 002081b3 80000054 80000058 9 1 0 0 00 00 00 00000000 0 0 0 0 0 0 0
1 00000073 80000058 8000005c a 2 1 1 00 00 00 00000000 0 0 0 0 0 0 0
1 ffffffff 8000005c 80000060 a 2 1 1 00 00 00 00000000 0 0 0 0 0 0 0
1 022081b3 80000060 80000064 b 3 1 1 00 00 00 00000000 0 0 0 0 0 0 0
0 00000073 80000064 80000068 b 3 0 0 00 00 00 00000000 0 0 0 0 0 0 0

//--- tb.f
+incdir+hdl
hdl/core_types_pkg.sv
hdl/decode_pkg.sv
hdl/pipe_reg.sv
hdl/inst_decoder.sv
hdl/decode_stage.sv
hdl/decode_top.sv
test/decode_props.sv
test/tb_decode.sv
